/* rtl/rx_pkg.sv */
/*
   shared widths, limits and types for the rx queue
   the word width is fixed at 64 bits with 8 byte lanes
*/
`default_nettype none

package rx_pkg;

   ////////////////////////////////////////////////////////////
   // widths and limits
   ////////////////////////////////////////////////////////////

   localparam int data_width     = 64;
   localparam int ctrl_width     = 8;
   localparam int lane_bits      = 3;
   localparam int max_pkt_size   = 2048;
   localparam int byte_cnt_width = 12;
   localparam int word_cnt_width = 9;

   typedef logic [byte_cnt_width-1:0] byte_cnt_t;
   typedef logic [word_cnt_width-1:0] word_cnt_t;

   // MAC side FSM
   typedef enum logic [2:0] {
      idle,
      receive,
      wait_status,
      add_pad,
      drop
   } ingress_state_t;

   ////////////////////////////////////////////////////////////
   // one output word, seen as byte lanes or as the header
   ////////////////////////////////////////////////////////////

   // lane 0 sits in bits 7:0 and holds the earliest byte
   typedef union packed {
      logic [ctrl_width-1:0][7:0] lanes;
      struct packed {
         logic [15:0] zero;
         logic [15:0] word_len;
         logic [15:0] src_port;
         logic [15:0] byte_len;
      } hdr;
   } out_word_u;

endpackage

`default_nettype wire

/* rtl/rx_buf_if.sv */
/*
   link between ingress, packet buffer and egress
   word_q and eop_lanes always show the head word
*/
`timescale 1ns/1ps
`default_nettype none

interface rx_buf_if;

   // byte write path
   logic                wr_en;
   logic [7:0]          wr_byte;
   logic                wr_eop;
   logic                prog_full;
   // per-frame status write
   logic                stat_wr;
   logic                stat_good;
   rx_pkg::byte_cnt_t   stat_len;
   // status read, head entry
   logic                stat_empty;
   logic                stat_good_q;
   rx_pkg::byte_cnt_t   stat_len_q;
   logic                stat_rd;
   // word read, first-word-fall-through
   logic                word_rd;
   rx_pkg::out_word_u   word_q;
   logic [7:0]          eop_lanes;

   modport ingress (
      output wr_en, wr_byte, wr_eop, stat_wr, stat_good, stat_len,
      input  prog_full
   );

   modport buffer (
      input  wr_en, wr_byte, wr_eop, stat_wr, stat_good, stat_len, stat_rd, word_rd,
      output prog_full, stat_empty, stat_good_q, stat_len_q, word_q, eop_lanes
   );

   modport egress (
      output stat_rd, word_rd,
      input  stat_empty, stat_good_q, stat_len_q, word_q, eop_lanes
   );

endinterface

`default_nettype wire

/* rtl/rx_ingress.sv */
/*
   admits a frame only if enabled and room for a max-size packet exists
   frames longer than max_pkt_size-1 bytes are cut to that length and marked bad
*/
`timescale 1ns/1ps
`default_nettype none

module rx_ingress (
   input  logic             rxcoreclk,
   input  logic             reset_rx_clk,
   input  logic [7:0]       gmac_rx_data,
   input  logic             gmac_rx_dvld,
   input  logic             gmac_rx_goodframe,
   input  logic             gmac_rx_badframe,
   input  logic             rx_queue_en,
   rx_buf_if.ingress        buf_wr,
   output logic             pkt_admit_eop,
   output logic             pkt_good,
   output logic             pkt_bad,
   output logic             pkt_dropped
);

   rx_pkg::ingress_state_t  state;
   rx_pkg::ingress_state_t  state_nxt;
   logic [7:0]              data_d1;
   logic                    dvld_d1;
   rx_pkg::byte_cnt_t       num_bytes;
   logic                    good_nxt;
   logic                    bad_nxt;
   logic                    drop_nxt;
   logic                    trunc;

   ////////////////////////////////////////////////////////////
   // frame FSM
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt      = state;
      buf_wr.wr_en   = 1'b0;
      buf_wr.wr_eop  = 1'b0;
      // pad bytes are zero
      buf_wr.wr_byte = (state == rx_pkg::add_pad) ? 8'h00 : data_d1;
      good_nxt       = 1'b0;
      bad_nxt        = 1'b0;
      drop_nxt       = 1'b0;
      trunc          = 1'b0;
      case (state)
         rx_pkg::idle: begin
            if (dvld_d1 && rx_queue_en && !buf_wr.prog_full) begin
               buf_wr.wr_en  = 1'b1;
               // single byte frame ends right here
               buf_wr.wr_eop = !gmac_rx_dvld;
               state_nxt     = gmac_rx_dvld ? rx_pkg::receive : rx_pkg::wait_status;
            end else if (dvld_d1) begin
               drop_nxt  = 1'b1;
               state_nxt = rx_pkg::drop;
            end
         end
         rx_pkg::receive: begin
            buf_wr.wr_en = 1'b1;
            // raw valid low, so data_d1 is the last byte
            if (!gmac_rx_dvld) begin
               buf_wr.wr_eop = 1'b1;
               state_nxt     = rx_pkg::wait_status;
            end else if (num_bytes >= rx_pkg::max_pkt_size - 2) begin
               buf_wr.wr_eop = 1'b1;
               trunc         = 1'b1;
               bad_nxt       = 1'b1;
               state_nxt     = rx_pkg::add_pad;
            end
         end
         // fcs result shows up some cycles after the last byte
         rx_pkg::wait_status: begin
            if (gmac_rx_goodframe) begin
               good_nxt  = 1'b1;
               state_nxt = rx_pkg::add_pad;
            end else if (gmac_rx_badframe) begin
               bad_nxt   = 1'b1;
               state_nxt = rx_pkg::add_pad;
            end
         end
         rx_pkg::add_pad: begin
            if (num_bytes[rx_pkg::lane_bits-1:0] == '0) begin
               // rest of a cut frame is still arriving
               state_nxt = dvld_d1 ? rx_pkg::drop : rx_pkg::idle;
            end else begin
               buf_wr.wr_en = 1'b1;
            end
         end
         rx_pkg::drop: begin
            if (!dvld_d1) begin
               state_nxt = rx_pkg::idle;
            end
         end
         default: state_nxt = rx_pkg::idle;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // registers and strobes
   ////////////////////////////////////////////////////////////

   always_ff @(posedge rxcoreclk) begin
      data_d1 <= gmac_rx_data;
      // status payload qualified by stat_wr
      buf_wr.stat_good <= good_nxt;
      buf_wr.stat_len  <= num_bytes + rx_pkg::byte_cnt_t'(buf_wr.wr_en);
      if (reset_rx_clk) begin
         state          <= rx_pkg::idle;
         dvld_d1        <= 1'b0;
         num_bytes      <= '0;
         buf_wr.stat_wr <= 1'b0;
         pkt_good       <= 1'b0;
         pkt_bad        <= 1'b0;
         pkt_dropped    <= 1'b0;
         pkt_admit_eop  <= 1'b0;
      end else begin
         state          <= state_nxt;
         dvld_d1        <= gmac_rx_dvld;
         buf_wr.stat_wr <= good_nxt | bad_nxt;
         pkt_good       <= good_nxt;
         pkt_bad        <= bad_nxt;
         pkt_dropped    <= drop_nxt;
         pkt_admit_eop  <= buf_wr.wr_en & buf_wr.wr_eop;
         if (buf_wr.wr_en) begin
            num_bytes <= num_bytes + 1'b1;
         end else if (state == rx_pkg::idle) begin
            num_bytes <= '0;
         end
      end
   end

   // nothing of a dropped frame reaches the buffer or the status FIFO
   assert property (@(posedge rxcoreclk) disable iff (reset_rx_clk)
      state == rx_pkg::drop |-> !buf_wr.wr_en && !buf_wr.stat_wr);

   // a cut frame is written back as bad with the cut length
   assert property (@(posedge rxcoreclk) disable iff (reset_rx_clk)
      trunc |=> buf_wr.stat_wr && !buf_wr.stat_good &&
                buf_wr.stat_len == rx_pkg::byte_cnt_t'(rx_pkg::max_pkt_size - 1));

endmodule

`default_nettype wire

/* rtl/rx_pkt_buffer.sv */
/*
   bytes in, 64-bit words out; every frame must start on lane 0
   status of the newest frame is held back until its last word is stored
*/
`timescale 1ns/1ps
`default_nettype none

module rx_pkt_buffer #(
   parameter int buf_depth_words = 1024,
   parameter int stat_depth      = 128
) (
   input  logic       rxcoreclk,
   input  logic       reset_rx_clk,
   rx_buf_if.buffer   wr_side
);

   localparam int aw = $clog2(buf_depth_words);
   localparam int sa = $clog2(stat_depth);

   rx_pkg::out_word_u              mem_data [buf_depth_words];
   logic [7:0]                     mem_eop  [buf_depth_words];
   logic                           stat_good_mem [stat_depth];
   rx_pkg::byte_cnt_t              stat_len_mem  [stat_depth];

   rx_pkg::out_word_u              acc;
   logic [7:0]                     acc_eop;
   rx_pkg::out_word_u              asm_word;
   logic [7:0]                     asm_eop;
   logic [rx_pkg::lane_bits-1:0]   lane;
   logic [aw:0]                    wptr;
   logic [aw:0]                    rptr;
   logic [aw:0]                    used;
   logic                           word_wr;
   logic [sa:0]                    swptr;
   logic [sa:0]                    srptr;
   logic [sa:0]                    st_cnt;

   ////////////////////////////////////////////////////////////
   // byte gather and word ring
   ////////////////////////////////////////////////////////////

   // current byte dropped into its lane
   always_comb begin
      asm_word             = acc;
      asm_eop              = acc_eop;
      asm_word.lanes[lane] = wr_side.wr_byte;
      asm_eop[lane]        = wr_side.wr_eop;
   end

   assign word_wr = wr_side.wr_en && (lane == '1);
   assign used    = wptr - rptr;

   // room for one max-size packet is missing
   assign wr_side.prog_full = (buf_depth_words - int'(used)) <
                              (rx_pkg::max_pkt_size / rx_pkg::ctrl_width);

   assign wr_side.word_q    = mem_data[rptr[aw-1:0]];
   assign wr_side.eop_lanes = mem_eop[rptr[aw-1:0]];

   always_ff @(posedge rxcoreclk) begin
      if (wr_side.wr_en) begin
         acc     <= asm_word;
         acc_eop <= asm_eop;
      end
      if (word_wr) begin
         mem_data[wptr[aw-1:0]] <= asm_word;
         mem_eop[wptr[aw-1:0]]  <= asm_eop;
      end
      if (reset_rx_clk) begin
         lane <= '0;
         wptr <= '0;
         rptr <= '0;
      end else begin
         if (wr_side.wr_en) lane <= lane + 1'b1;
         if (word_wr)         wptr <= wptr + 1'b1;
         if (wr_side.word_rd) rptr <= rptr + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // status FIFO
   ////////////////////////////////////////////////////////////

   assign st_cnt = swptr - srptr;
   // pad bytes may still be pending for the only frame with status
   assign wr_side.stat_empty  = (st_cnt == '0) || (st_cnt == 1 && lane != '0);
   assign wr_side.stat_good_q = stat_good_mem[srptr[sa-1:0]];
   assign wr_side.stat_len_q  = stat_len_mem[srptr[sa-1:0]];

   always_ff @(posedge rxcoreclk) begin
      if (wr_side.stat_wr) begin
         stat_good_mem[swptr[sa-1:0]] <= wr_side.stat_good;
         stat_len_mem[swptr[sa-1:0]]  <= wr_side.stat_len;
      end
      if (reset_rx_clk) begin
         swptr <= '0;
         srptr <= '0;
      end else begin
         if (wr_side.stat_wr) swptr <= swptr + 1'b1;
         if (wr_side.stat_rd) srptr <= srptr + 1'b1;
      end
   end

   // ingress admission keeps the ring from overflowing
   assert property (@(posedge rxcoreclk) disable iff (reset_rx_clk)
      word_wr |-> !used[aw]);

   // egress pops only a visible entry
   assert property (@(posedge rxcoreclk) disable iff (reset_rx_clk)
      wr_side.stat_rd |-> !wr_side.stat_empty);

endmodule

`default_nettype wire

/* rtl/rx_egress.sv */
/*
   good frames go out as words with an optional header in front
   bad frames drain at one word per cycle, out_rdy ignored
*/
`timescale 1ns/1ps
`default_nettype none

module rx_egress #(
   parameter bit         enable_header = 1'b0,
   parameter logic [7:0] stage_number  = 8'hff,
   parameter int         port_number   = 0
) (
   input  logic                rxcoreclk,
   input  logic                reset_rx_clk,
   rx_buf_if.egress            rd_side,
   output logic [63:0]         out_data,
   output logic [7:0]          out_ctrl,
   output logic                out_wr,
   input  logic                out_rdy,
   output rx_pkg::byte_cnt_t   rx_pkt_byte_cnt,
   output rx_pkg::word_cnt_t   rx_pkt_word_cnt,
   output logic                rx_pkt_pulled
);

   localparam logic [1:0] out_wait   = 2'd0;
   localparam logic [1:0] out_header = 2'd1;
   localparam logic [1:0] out_stream = 2'd2;

   logic [1:0]          state;
   logic [1:0]          state_nxt;
   logic                cur_good;
   rx_pkg::byte_cnt_t   cur_len;
   rx_pkg::word_cnt_t   word_len;
   rx_pkg::out_word_u   hdr_word;
   logic                output_len;
   logic                out_wr_nxt;
   logic                pulled_nxt;

   // bytes rounded up to whole words
   assign word_len = cur_len[rx_pkg::byte_cnt_width-1:rx_pkg::lane_bits] +
                     rx_pkg::word_cnt_t'(cur_len[rx_pkg::lane_bits-1:0] != '0);

   assign hdr_word.hdr.zero     = '0;
   assign hdr_word.hdr.word_len = 16'(word_len);
   assign hdr_word.hdr.src_port = 16'(port_number);
   assign hdr_word.hdr.byte_len = 16'(cur_len);

   ////////////////////////////////////////////////////////////
   // output FSM
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt       = state;
      rd_side.stat_rd = 1'b0;
      rd_side.word_rd = 1'b0;
      output_len      = 1'b0;
      out_wr_nxt      = 1'b0;
      pulled_nxt      = 1'b0;
      case (state)
         out_wait: begin
            if (!rd_side.stat_empty) begin
               rd_side.stat_rd = 1'b1;
               state_nxt       = enable_header ? out_header : out_stream;
            end
         end
         out_header: begin
            output_len = 1'b1;
            out_wr_nxt = cur_good & out_rdy;
            if (out_rdy || !cur_good) state_nxt = out_stream;
         end
         out_stream: begin
            // word accepted, or thrown away for a bad frame
            if (out_rdy || !cur_good) begin
               rd_side.word_rd = 1'b1;
               out_wr_nxt      = cur_good;
               if (|rd_side.eop_lanes) begin
                  pulled_nxt = cur_good;
                  state_nxt  = out_wait;
               end
            end
         end
         default: state_nxt = out_wait;
      endcase
   end

   always_ff @(posedge rxcoreclk) begin
      // head status is gone after the pop, keep a copy
      if (rd_side.stat_rd) begin
         cur_good <= rd_side.stat_good_q;
         cur_len  <= rd_side.stat_len_q;
      end
      out_data        <= output_len ? hdr_word : rd_side.word_q;
      out_ctrl        <= output_len ? stage_number : rd_side.eop_lanes;
      rx_pkt_byte_cnt <= cur_len;
      rx_pkt_word_cnt <= word_len;
      if (reset_rx_clk) begin
         state         <= out_wait;
         out_wr        <= 1'b0;
         rx_pkt_pulled <= 1'b0;
      end else begin
         state         <= state_nxt;
         out_wr        <= out_wr_nxt;
         rx_pkt_pulled <= pulled_nxt;
      end
   end

   // header word must carry a nonzero ctrl for the next stage
   assert property (@(posedge rxcoreclk) disable iff (reset_rx_clk)
      state == out_header && out_wr_nxt |=> out_wr && out_ctrl != '0);

endmodule

`default_nettype wire

/* rtl/rx_rate_meter.sv */
/*
   counts admitted frame ends per window of rate_window cycles
   a frame ending on the last window cycle counts toward the next window
*/
`timescale 1ns/1ps
`default_nettype none

module rx_rate_meter #(
   parameter int unsigned rate_window = 125000000
) (
   input  logic         rxcoreclk,
   input  logic         reset_rx_clk,
   input  logic         pkt_admit_eop,
   output logic [31:0]  rate_packet
);

   logic [31:0] window_cnt;
   logic [31:0] pkt_cnt;

   always_ff @(posedge rxcoreclk) begin
      if (reset_rx_clk) begin
         window_cnt  <= '0;
         pkt_cnt     <= '0;
         rate_packet <= '0;
      end else if (window_cnt == rate_window - 1) begin
         // publish and restart
         window_cnt  <= '0;
         rate_packet <= pkt_cnt;
         pkt_cnt     <= 32'(pkt_admit_eop);
      end else begin
         window_cnt <= window_cnt + 1'b1;
         pkt_cnt    <= pkt_cnt + 32'(pkt_admit_eop);
      end
   end

endmodule

`default_nettype wire

/* rtl/rx_queue.sv */
/*
   single clock receive queue, 64-bit output words
   enable_header puts a length and source port word before each frame
*/
`timescale 1ns/1ps
`default_nettype none

module rx_queue #(
   parameter bit          enable_header   = 1'b0,
   parameter logic [7:0]  stage_number    = 8'hff,
   parameter int          port_number     = 0,
   parameter int unsigned rate_window     = 125000000,
   parameter int          buf_depth_words = 1024,
   parameter int          stat_depth      = 128
) (
   input  logic                rxcoreclk,
   input  logic                reset_rx_clk,
   // MAC side
   input  logic [7:0]          gmac_rx_data,
   input  logic                gmac_rx_dvld,
   input  logic                gmac_rx_goodframe,
   input  logic                gmac_rx_badframe,
   input  logic                rx_queue_en,
   // next stage
   output logic [63:0]         out_data,
   output logic [7:0]          out_ctrl,
   output logic                out_wr,
   input  logic                out_rdy,
   // event and status outputs
   output logic                rx_pkt_good,
   output logic                rx_pkt_bad,
   output logic                rx_pkt_dropped,
   output rx_pkg::byte_cnt_t   rx_pkt_byte_cnt,
   output rx_pkg::word_cnt_t   rx_pkt_word_cnt,
   output logic                rx_pkt_pulled,
   output logic [31:0]         rate_packet
);

   logic pkt_admit_eop;

   rx_buf_if buf_bus ();

   rx_ingress u_ingress (
      .rxcoreclk         (rxcoreclk),
      .reset_rx_clk      (reset_rx_clk),
      .gmac_rx_data      (gmac_rx_data),
      .gmac_rx_dvld      (gmac_rx_dvld),
      .gmac_rx_goodframe (gmac_rx_goodframe),
      .gmac_rx_badframe  (gmac_rx_badframe),
      .rx_queue_en       (rx_queue_en),
      .buf_wr            (buf_bus.ingress),
      .pkt_admit_eop     (pkt_admit_eop),
      .pkt_good          (rx_pkt_good),
      .pkt_bad           (rx_pkt_bad),
      .pkt_dropped       (rx_pkt_dropped)
   );

   rx_pkt_buffer #(
      .buf_depth_words (buf_depth_words),
      .stat_depth      (stat_depth)
   ) u_pkt_buffer (
      .rxcoreclk    (rxcoreclk),
      .reset_rx_clk (reset_rx_clk),
      .wr_side      (buf_bus.buffer)
   );

   rx_egress #(
      .enable_header (enable_header),
      .stage_number  (stage_number),
      .port_number   (port_number)
   ) u_egress (
      .rxcoreclk       (rxcoreclk),
      .reset_rx_clk    (reset_rx_clk),
      .rd_side         (buf_bus.egress),
      .out_data        (out_data),
      .out_ctrl        (out_ctrl),
      .out_wr          (out_wr),
      .out_rdy         (out_rdy),
      .rx_pkt_byte_cnt (rx_pkt_byte_cnt),
      .rx_pkt_word_cnt (rx_pkt_word_cnt),
      .rx_pkt_pulled   (rx_pkt_pulled)
   );

   rx_rate_meter #(
      .rate_window (rate_window)
   ) u_rate_meter (
      .rxcoreclk     (rxcoreclk),
      .reset_rx_clk  (reset_rx_clk),
      .pkt_admit_eop (pkt_admit_eop),
      .rate_packet   (rate_packet)
   );

endmodule

`default_nettype wire

/* verif/rx_queue_checker.sv */
/*
   passive checker, expects the DUT built with the header word enabled
   frames that reach 2048 bytes are taken as cut and bad; buffer never near full
*/
`timescale 1ns/1ps
`default_nettype none

module rx_queue_checker #(
   parameter int port_number = 0,
   parameter int rate_window = 4000
) (
   input  logic                rxcoreclk,
   input  logic                reset_rx_clk,
   input  logic [7:0]          gmac_rx_data,
   input  logic                gmac_rx_dvld,
   input  logic                gmac_rx_goodframe,
   input  logic                gmac_rx_badframe,
   input  logic                rx_queue_en,
   input  logic [63:0]         out_data,
   input  logic [7:0]          out_ctrl,
   input  logic                out_wr,
   input  logic                out_rdy,
   input  logic                rx_pkt_good,
   input  logic                rx_pkt_bad,
   input  logic                rx_pkt_dropped,
   input  rx_pkg::byte_cnt_t   rx_pkt_byte_cnt,
   input  rx_pkg::word_cnt_t   rx_pkt_word_cnt,
   input  logic                rx_pkt_pulled,
   input  logic [31:0]         rate_packet,
   input  logic [127:0]        test_name,
   output int                  value_errors,
   output int                  other_errors
);

   // expected output words, one entry per out_wr
   logic [63:0]  exp_data [$];
   logic [7:0]   exp_ctrl [$];
   logic [127:0] exp_name [$];
   // expected counts per pulled packet
   int           exp_bytes [$];
   int           exp_words [$];
   logic [127:0] pull_name [$];
   // frame being received from the MAC
   logic [7:0]   cur_bytes [$];
   logic [127:0] cur_name;
   logic [127:0] pop_name;
   bit           in_frame;
   bit           dropped;
   bit           trunc;
   bit           await_status;
   bit           rdy_prev;
   int           j;
   int           w;
   int           exp_good, exp_bad, exp_drop;
   int           act_good, act_bad, act_drop;
   int           win_cnt [64];

   initial begin
      value_errors = 0;
      other_errors = 0;
      exp_good     = 0;
      exp_bad      = 0;
      exp_drop     = 0;
      act_good     = 0;
      act_bad      = 0;
      act_drop     = 0;
      foreach (win_cnt[i]) win_cnt[i] = 0;
   end

   task automatic report_value(input logic [127:0] name, input string what,
                               input logic [63:0] exp_v, input logic [63:0] act_v);
      $display("ERROR %0s: %0s expected %0h actual %0h", name, what, exp_v, act_v);
      value_errors++;
   endtask

   // frame end reaches the rate meter one cycle after this sample
   task automatic note_admit();
      int wi;
      wi = (j + 1) / rate_window + 1;
      if (wi < 64) win_cnt[wi]++;
   endtask

   // header, then lane-ordered words, pad bytes zero
   task automatic push_good_frame();
      int          len;
      int          words;
      logic [63:0] word;
      logic [7:0]  ctrl;
      len   = cur_bytes.size();
      words = (len + 7) / 8;
      exp_data.push_back({16'h0, 16'(words), 16'(port_number), 16'(len)});
      exp_ctrl.push_back(8'hff);
      exp_name.push_back(cur_name);
      for (int wd = 0; wd < words; wd++) begin
         word = '0;
         ctrl = '0;
         for (int b = 0; b < 8; b++) begin
            if (wd * 8 + b < len) word[8*b +: 8] = cur_bytes[wd * 8 + b];
         end
         // only the lane of the last real byte
         if (wd == words - 1) ctrl[(len - 1) % 8] = 1'b1;
         exp_data.push_back(word);
         exp_ctrl.push_back(ctrl);
         exp_name.push_back(cur_name);
      end
      exp_bytes.push_back(len);
      exp_words.push_back(words);
      pull_name.push_back(cur_name);
   endtask

   ////////////////////////////////////////////////////////////
   // per-cycle watch of both sides
   ////////////////////////////////////////////////////////////

   always @(posedge rxcoreclk) begin
      if (reset_rx_clk) begin
         j            = 0;
         in_frame     = 0;
         await_status = 0;
         rdy_prev     = 1;
      end else begin
         j = j + 1;
         // MAC side
         if (gmac_rx_dvld) begin
            if (!in_frame) begin
               in_frame = 1;
               cur_bytes.delete();
               cur_name     = test_name;
               dropped      = !rx_queue_en;
               trunc        = 0;
               await_status = 0;
               if (dropped) exp_drop++;
            end
            cur_bytes.push_back(gmac_rx_data);
            if (!dropped && !trunc && cur_bytes.size() == 2048) begin
               trunc = 1;
               exp_bad++;
               note_admit();
            end
         end else if (in_frame) begin
            in_frame = 0;
            if (!dropped && !trunc) begin
               await_status = 1;
               note_admit();
            end
         end else if (await_status && (gmac_rx_goodframe || gmac_rx_badframe)) begin
            await_status = 0;
            if (gmac_rx_goodframe) begin
               exp_good++;
               push_good_frame();
            end else begin
               exp_bad++;
            end
         end
         // output side
         if (out_wr) begin
            if (!rdy_prev) begin
               $display("out_wr seen in the cycle after out_rdy was low");
               other_errors++;
            end
            if (exp_data.size() == 0) begin
               $display("output word %0h arrived with no frame expected", out_data);
               other_errors++;
            end else begin
               pop_name = exp_name.pop_front();
               report_if_diff(pop_name, "out_data", exp_data.pop_front(), out_data);
               report_if_diff(pop_name, "out_ctrl", exp_ctrl.pop_front(), out_ctrl);
            end
         end
         if (rx_pkt_pulled) begin
            if (exp_bytes.size() == 0) begin
               $display("rx_pkt_pulled pulsed with no good frame pending");
               other_errors++;
            end else begin
               pop_name = pull_name.pop_front();
               report_if_diff(pop_name, "byte count", exp_bytes.pop_front(), rx_pkt_byte_cnt);
               report_if_diff(pop_name, "word count", exp_words.pop_front(), rx_pkt_word_cnt);
            end
         end
         act_good += rx_pkt_good;
         act_bad  += rx_pkt_bad;
         act_drop += rx_pkt_dropped;
         // new rate value visible one cycle after window end
         if (j > rate_window && j % rate_window == 1) begin
            w = (j - 1) / rate_window;
            if (w < 64) report_if_diff("rate_meter", "rate_packet", win_cnt[w], rate_packet);
         end
         rdy_prev = out_rdy;
      end
   end

   task automatic report_if_diff(input logic [127:0] name, input string what,
                                 input logic [63:0] exp_v, input logic [63:0] act_v);
      if (exp_v !== act_v) report_value(name, what, exp_v, act_v);
   endtask

   // end of run, event totals and leftovers
   task automatic final_check();
      report_if_diff("event_counts", "good pulses", exp_good, act_good);
      report_if_diff("event_counts", "bad pulses", exp_bad, act_bad);
      report_if_diff("event_counts", "dropped pulses", exp_drop, act_drop);
      if (exp_data.size() != 0) begin
         $display("%0d expected output words never appeared", exp_data.size());
         other_errors++;
      end
      if (exp_bytes.size() != 0) begin
         $display("%0d good frames never pulsed rx_pkt_pulled", exp_bytes.size());
         other_errors++;
      end
   endtask

endmodule

`default_nettype wire

/* verif/rx_queue_tb.sv */
/*
   frame table run in order with one frame in flight on the MAC side
   DUT built with header on, port 3 and a 4000 cycle rate window
*/
`timescale 1ns/1ps
`default_nettype none

module rx_queue_tb;

   localparam int port_no    = 3;
   localparam int window     = 4000;
   localparam int n_tests    = 11;
   localparam int gap_cycles = 40;

   logic               rxcoreclk;
   logic               reset_rx_clk;
   logic [7:0]         gmac_rx_data;
   logic               gmac_rx_dvld;
   logic               gmac_rx_goodframe;
   logic               gmac_rx_badframe;
   logic               rx_queue_en;
   logic [63:0]        out_data;
   logic [7:0]         out_ctrl;
   logic               out_wr;
   logic               out_rdy;
   logic               rx_pkt_good;
   logic               rx_pkt_bad;
   logic               rx_pkt_dropped;
   rx_pkg::byte_cnt_t  rx_pkt_byte_cnt;
   rx_pkg::word_cnt_t  rx_pkt_word_cnt;
   logic               rx_pkt_pulled;
   logic [31:0]        rate_packet;
   logic [127:0]       test_name;
   logic [7:0]         stall_pat;
   logic [2:0]         stall_idx;
   integer             seed;
   int                 done_cnt;
   int                 tb_errors;
   int                 value_errors;
   int                 other_errors;
   int                 watchdog_cycles;

   ////////////////////////////////////////////////////////////
   // frame table
   ////////////////////////////////////////////////////////////

   logic [127:0] names [n_tests] = '{"good_64", "good_1", "good_77", "bad_crc",
      "good_after_bad", "queue_off", "oversize", "after_oversize", "stall_a",
      "stall_b", "good_2046"};
   int           lengths [n_tests] = '{64, 1, 77, 100, 45, 80, 2100, 130, 300, 1500, 2046};
   bit           goods   [n_tests] = '{1, 1, 1, 0, 1, 1, 1, 1, 1, 1, 1};
   bit           enables [n_tests] = '{1, 1, 1, 1, 1, 0, 1, 1, 1, 1, 1};
   // rotating out_rdy bit per cycle
   logic [7:0]   stalls  [n_tests] = '{8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff,
      8'hff, 8'hff, 8'b1010_0110, 8'b0001_0001, 8'b1101_1011};

   rx_queue #(
      .enable_header (1'b1),
      .port_number   (port_no),
      .rate_window   (window)
   ) UUT (
      .rxcoreclk (rxcoreclk), .reset_rx_clk (reset_rx_clk),
      .gmac_rx_data (gmac_rx_data), .gmac_rx_dvld (gmac_rx_dvld),
      .gmac_rx_goodframe (gmac_rx_goodframe), .gmac_rx_badframe (gmac_rx_badframe),
      .rx_queue_en (rx_queue_en), .out_data (out_data), .out_ctrl (out_ctrl),
      .out_wr (out_wr), .out_rdy (out_rdy), .rx_pkt_good (rx_pkt_good),
      .rx_pkt_bad (rx_pkt_bad), .rx_pkt_dropped (rx_pkt_dropped),
      .rx_pkt_byte_cnt (rx_pkt_byte_cnt), .rx_pkt_word_cnt (rx_pkt_word_cnt),
      .rx_pkt_pulled (rx_pkt_pulled), .rate_packet (rate_packet)
   );

   rx_queue_checker #(
      .port_number (port_no),
      .rate_window (window)
   ) u_checker (
      .rxcoreclk (rxcoreclk), .reset_rx_clk (reset_rx_clk),
      .gmac_rx_data (gmac_rx_data), .gmac_rx_dvld (gmac_rx_dvld),
      .gmac_rx_goodframe (gmac_rx_goodframe), .gmac_rx_badframe (gmac_rx_badframe),
      .rx_queue_en (rx_queue_en), .out_data (out_data), .out_ctrl (out_ctrl),
      .out_wr (out_wr), .out_rdy (out_rdy), .rx_pkt_good (rx_pkt_good),
      .rx_pkt_bad (rx_pkt_bad), .rx_pkt_dropped (rx_pkt_dropped),
      .rx_pkt_byte_cnt (rx_pkt_byte_cnt), .rx_pkt_word_cnt (rx_pkt_word_cnt),
      .rx_pkt_pulled (rx_pkt_pulled), .rate_packet (rate_packet),
      .test_name (test_name), .value_errors (value_errors),
      .other_errors (other_errors)
   );

   // 100 ns period
   always #50 rxcoreclk = ~rxcoreclk;

   // back-pressure from the current stall pattern
   always @(posedge rxcoreclk) begin
      #5;
      out_rdy   = stall_pat[stall_idx];
      stall_idx = stall_idx + 1'b1;
   end

   // each frame ends in exactly one of these
   always @(posedge rxcoreclk) begin
      if (!reset_rx_clk) begin
         done_cnt <= done_cnt + rx_pkt_pulled + rx_pkt_bad + rx_pkt_dropped;
      end
   end

   task automatic send_frame(input int idx);
      test_name   = names[idx];
      rx_queue_en = enables[idx];
      stall_pat  <= stalls[idx];
      for (int i = 0; i < lengths[idx]; i++) begin
         gmac_rx_data = 8'($random(seed));
         gmac_rx_dvld = 1'b1;
         @(posedge rxcoreclk);
         #5;
      end
      gmac_rx_dvld = 1'b0;
      gmac_rx_data = 8'h00;
      // fcs result one cycle after valid falls
      @(posedge rxcoreclk);
      #5;
      gmac_rx_goodframe = goods[idx];
      gmac_rx_badframe  = !goods[idx];
      @(posedge rxcoreclk);
      #5;
      gmac_rx_goodframe = 1'b0;
      gmac_rx_badframe  = 1'b0;
      rx_queue_en       = 1'b1;
   endtask

   task automatic wait_done(input int target, input int limit);
      int n;
      n = 0;
      while (done_cnt < target && n < limit) begin
         @(posedge rxcoreclk);
         #5;
         n++;
      end
      if (done_cnt < target) begin
         $display("frame %0s did not finish within %0d cycles", test_name, limit);
         tb_errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      rxcoreclk         = 1'b0;
      reset_rx_clk      = 1'b1;
      gmac_rx_data      = 8'h00;
      gmac_rx_dvld      = 1'b0;
      gmac_rx_goodframe = 1'b0;
      gmac_rx_badframe  = 1'b0;
      rx_queue_en       = 1'b1;
      out_rdy           = 1'b1;
      stall_pat         = 8'hff;
      stall_idx         = 3'd0;
      test_name         = "reset";
      seed              = 95;
      done_cnt          = 0;
      tb_errors         = 0;
      repeat (8) @(posedge rxcoreclk);
      #5;
      reset_rx_clk = 1'b0;
      repeat (4) @(posedge rxcoreclk);
      #5;
      for (int t = 0; t < n_tests; t++) begin
         send_frame(t);
         wait_done(t + 1, 4 * lengths[t] + 200);
         repeat (8) @(posedge rxcoreclk);
         #5;
      end
      // let the last rate window close
      repeat (window + 2) @(posedge rxcoreclk);
      #5;
      u_checker.final_check();
      $display("errors: value %0d, other %0d, testbench %0d",
               value_errors, other_errors, tb_errors);
      if (value_errors + other_errors + tb_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // bound from the table lengths plus per-frame gaps
   initial begin
      watchdog_cycles = 0;
      for (int t = 0; t < n_tests; t++) watchdog_cycles += lengths[t] + gap_cycles;
      watchdog_cycles = watchdog_cycles * 4 + 2 * window;
      repeat (watchdog_cycles) @(posedge rxcoreclk);
      $display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* rx_queue.f */
rtl/rx_pkg.sv
rtl/rx_buf_if.sv
rtl/rx_ingress.sv
rtl/rx_pkt_buffer.sv
rtl/rx_egress.sv
rtl/rx_rate_meter.sv
rtl/rx_queue.sv
verif/rx_queue_checker.sv
verif/rx_queue_tb.sv
